// File: mcp_data_chip.f
+incdir+test
rtl/mcp_pkg.sv
rtl/mcp_rf_if.sv
rtl/mcp_alu_if.sv
rtl/mcp_regfile.sv
rtl/mcp_alu.sv
rtl/mcp_psw.sv
rtl/mcp_mir_ctrl.sv
rtl/mcp_data_chip.sv
test/tb_mcp_data_chip.sv

// File: rtl/mcp_alu.sv
// 8-bit ALU built from OR/AND subfunction tables and a ripple carry chain
`timescale 1ns/1ps

module mcp_alu
(
   mcp_alu_if.alu a
);

   logic [3:0]                  or_tab;    // OR subfunction, indexed by {fa, fb}
   logic [3:0]                  and_tab;   // AND subfunction, indexed by {fa, fb}
   logic                        ci;        // carry into bit 0
   logic                        shift;
   logic                        arith;
   logic                        borrow;    // carry out means no borrow
   mcp_pkg::byte_t              ax;
   mcp_pkg::byte_t              ay;
   mcp_pkg::byte_t              sum;
   mcp_pkg::byte_t              res;
   logic [mcp_pkg::DATA_W:0]    cc;        // carry chain, cc[0] is the carry-in

   always_comb
   begin
      or_tab  = 4'b0000;
      and_tab = 4'b0000;
      ci      = 1'b0;
      shift   = 1'b0;
      arith   = 1'b0;
      borrow  = 1'b0;
      case (a.fn)
         mcp_pkg::FN_ADD:
         begin
            or_tab  = 4'b0110;             // half sum
            and_tab = 4'b1000;             // generate
            arith   = 1'b1;
         end
         mcp_pkg::FN_ADC:
         begin
            or_tab  = 4'b0110;
            and_tab = 4'b1000;
            ci      = a.cin;
            arith   = 1'b1;
         end
         mcp_pkg::FN_SUB:
         begin
            or_tab  = 4'b1001;             // a xnor b, i.e. a + ~b
            and_tab = 4'b0100;
            ci      = 1'b1;
            arith   = 1'b1;
            borrow  = 1'b1;
         end
         mcp_pkg::FN_AND:  or_tab = 4'b1000;
         mcp_pkg::FN_OR:   or_tab = 4'b1110;
         mcp_pkg::FN_XOR:  or_tab = 4'b0110;
         mcp_pkg::FN_MOVB: or_tab = 4'b1010;
         mcp_pkg::FN_SHR:
         begin
            or_tab = 4'b1100;              // pass A, shifted below
            shift  = 1'b1;
         end
         default: ;
      endcase
   end

   always_comb
   begin
      cc[0] = ci;
      for (int i = 0; i < mcp_pkg::DATA_W; i++)
      begin
         ax[i]    = or_tab[{a.fa[i], a.fb[i]}];
         ay[i]    = and_tab[{a.fa[i], a.fb[i]}];
         sum[i]   = ax[i] ^ cc[i];
         cc[i+1]  = ay[i] | (ax[i] & cc[i]);
      end
   end

   assign res = shift ? {a.cin, sum[mcp_pkg::DATA_W-1:1]} : sum;   // old C into bit 7

   assign a.result = res;
   assign a.n      = res[mcp_pkg::DATA_W-1];
   assign a.z      = (res == '0);
   assign a.v      = arith & (cc[mcp_pkg::DATA_W] ^ cc[mcp_pkg::DATA_W-1]);
   assign a.c      = shift ? a.fa[0] : (cc[mcp_pkg::DATA_W] ^ borrow);

endmodule

// File: rtl/mcp_alu_if.sv
// ALU operand, function and flag bundle shared by control, ALU and status word
`timescale 1ns/1ps

interface mcp_alu_if;

   mcp_pkg::byte_t   fa;                   // port A
   mcp_pkg::byte_t   fb;                   // port B
   mcp_pkg::alu_fn_t fn;
   logic             go;                   // operation accepted this cycle
   logic             cin;                  // stored carry
   mcp_pkg::byte_t   result;
   logic             c;
   logic             v;
   logic             z;
   logic             n;

   modport ctrl (output fa, fb, fn, go, input result);

   modport alu (input fa, fb, fn, cin, output result, c, v, z, n);

   modport psw (input fn, go, c, v, z, n, output cin);

endinterface

// File: rtl/mcp_data_chip.sv
// data chip top level, joins register file, ALU, status word and control
`timescale 1ns/1ps

module mcp_data_chip
(
   input  logic             clk,
   input  logic             reset,
   input  mcp_pkg::word_t   mi,
   input  mcp_pkg::alu_fn_t fn,
   input  logic             valid,
   input  logic             wi,
   output mcp_pkg::word_t   ad,
   output logic             ad_stb,
   output mcp_pkg::byte_t   psw
);

   mcp_pkg::byte_t fb;                     // port B, also the PSW load value

   mcp_rf_if  rf_bus ();
   mcp_alu_if alu_bus ();

   mcp_regfile regfile0
   (
      .clk     (clk),
      .reset   (reset),
      .rf      (rf_bus)
   );

   mcp_alu alu0
   (
      .a       (alu_bus)
   );

   mcp_psw psw0
   (
      .clk      (clk),
      .reset    (reset),
      .a        (alu_bus),
      .ld_value (fb),
      .psw      (psw)
   );

   mcp_mir_ctrl ctrl0
   (
      .clk     (clk),
      .reset   (reset),
      .mi      (mi),
      .fn      (fn),
      .valid   (valid),
      .wi      (wi),
      .rf      (rf_bus),
      .a       (alu_bus),
      .fb      (fb),
      .ad      (ad),
      .ad_stb  (ad_stb)
   );

endmodule

// File: rtl/mcp_mir_ctrl.sv
// microinstruction field decode, port B select, write strobes and AD output latch
`timescale 1ns/1ps

module mcp_mir_ctrl
(
   input  logic             clk,
   input  logic             reset,
   input  mcp_pkg::word_t   mi,
   input  mcp_pkg::alu_fn_t fn,
   input  logic             valid,
   input  logic             wi,            // wait, holds everything
   mcp_rf_if.ctrl           rf,
   mcp_alu_if.ctrl          a,
   output mcp_pkg::byte_t   fb,
   output mcp_pkg::word_t   ad,
   output logic             ad_stb
);

   logic go;
   logic wr_result;                        // function writes register A

   assign go = valid & ~wi;

   always_comb
   begin
      case (fn)
         mcp_pkg::FN_ADD, mcp_pkg::FN_ADC, mcp_pkg::FN_SUB, mcp_pkg::FN_AND,
         mcp_pkg::FN_OR, mcp_pkg::FN_XOR, mcp_pkg::FN_MOVB, mcp_pkg::FN_SHR:
            wr_result = 1'b1;
         default:
            wr_result = 1'b0;
      endcase
   end

   // field split of the microinstruction
   assign rf.sel_a = mi[3:0];
   assign rf.sel_b = mi[7:4];

   assign fb = mi[mcp_pkg::MI_BREG_BIT] ? rf.rb : mi[11:4];   // register or immediate

   assign a.fa = rf.ra;
   assign a.fb = fb;
   assign a.fn = fn;
   assign a.go = go;

   assign rf.wdata = a.result;
   assign rf.we    = go & wr_result;
   assign rf.g_we  = go & (fn == mcp_pkg::FN_LDG);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ad     <= '0;
         ad_stb <= 1'b0;
      end
      else
      begin
         ad_stb <= go & (fn == mcp_pkg::FN_OUT);      // one cycle pulse
         if (go && fn == mcp_pkg::FN_OUT)
            ad <= {fb, rf.ra};                        // held until the next FN_OUT
      end
   end

endmodule

// File: rtl/mcp_pkg.sv
// shared widths, types and constants of the MCP-1611 data path model
package mcp_pkg;

   localparam int DATA_W = 8;              // register and ALU port width
   localparam int WORD_W = 16;             // microinstruction and AD bus width
   localparam int SEL_W  = 4;              // register selector field
   localparam int BANK_W = 3;              // width of G
   localparam int IDX_W  = 5;              // physical register index

   typedef logic [DATA_W-1:0] byte_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [SEL_W-1:0]  reg_sel_t;
   typedef logic [BANK_W-1:0] bank_t;
   typedef logic [IDX_W-1:0]  reg_idx_t;

   // explicit function code in place of the decoded microinstruction
   typedef enum logic [3:0] {
      FN_NOP   = 4'd0,
      FN_ADD   = 4'd1,
      FN_ADC   = 4'd2,
      FN_SUB   = 4'd3,
      FN_AND   = 4'd4,
      FN_OR    = 4'd5,
      FN_XOR   = 4'd6,
      FN_MOVB  = 4'd7,
      FN_SHR   = 4'd8,
      FN_LDG   = 4'd9,
      FN_LDPSW = 4'd10,
      FN_OUT   = 4'd11
   } alu_fn_t;

   localparam int NUM_REGS     = 26;       // general registers
   localparam int BANKED_SELS  = 2;        // selectors 0 and 1 follow G
   localparam int REG_MAP_BASE = 27;       // other selectors map to base - sel

   localparam int PSW_C = 0;               // carry
   localparam int PSW_V = 1;               // overflow
   localparam int PSW_Z = 2;               // zero
   localparam int PSW_N = 3;               // negative

   localparam int MI_BREG_BIT = 15;        // port B from register B when set

endpackage

// File: rtl/mcp_psw.sv
// processor status word with per-function flag update and direct load
`timescale 1ns/1ps

module mcp_psw
(
   input  logic           clk,
   input  logic           reset,
   mcp_alu_if.psw         a,
   input  mcp_pkg::byte_t ld_value,
   output mcp_pkg::byte_t psw
);

   logic upd_c;                            // carry producing functions
   logic upd_vzn;                          // all result functions

   always_comb
   begin
      upd_c   = 1'b0;
      upd_vzn = 1'b0;
      case (a.fn)
         mcp_pkg::FN_ADD, mcp_pkg::FN_ADC, mcp_pkg::FN_SUB, mcp_pkg::FN_SHR:
         begin
            upd_c   = 1'b1;
            upd_vzn = 1'b1;
         end
         mcp_pkg::FN_AND, mcp_pkg::FN_OR, mcp_pkg::FN_XOR, mcp_pkg::FN_MOVB:
            upd_vzn = 1'b1;                // C is kept
         default: ;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         psw <= '0;
      else if (a.go)
      begin
         if (a.fn == mcp_pkg::FN_LDPSW)
            psw <= ld_value;               // whole byte from port B
         if (upd_c)
            psw[mcp_pkg::PSW_C] <= a.c;
         if (upd_vzn)
         begin
            psw[mcp_pkg::PSW_V] <= a.v;
            psw[mcp_pkg::PSW_Z] <= a.z;
            psw[mcp_pkg::PSW_N] <= a.n;
         end
      end
   end

   assign a.cin = psw[mcp_pkg::PSW_C];

endmodule

// File: rtl/mcp_regfile.sv
// 26x8 register file with two read ports, one write port and bank register G
`timescale 1ns/1ps

module mcp_regfile
(
   input  logic clk,
   input  logic reset,
   mcp_rf_if.rf rf
);

   mcp_pkg::byte_t    regs [mcp_pkg::NUM_REGS];
   mcp_pkg::bank_t    g;                   // bank for selectors 0 and 1
   mcp_pkg::reg_idx_t idx_a;
   mcp_pkg::reg_idx_t idx_b;

   // selectors 0/1 pick a pair by G, the rest count down from the top
   function automatic mcp_pkg::reg_idx_t map_sel
   (
      mcp_pkg::reg_sel_t s,
      mcp_pkg::bank_t    bank
   );
      mcp_pkg::reg_idx_t idx;
      if (s < mcp_pkg::reg_sel_t'(mcp_pkg::BANKED_SELS))
      begin
         idx = mcp_pkg::reg_idx_t'({bank, 1'b0}) + mcp_pkg::reg_idx_t'(s);
      end
      else
      begin
         idx = mcp_pkg::reg_idx_t'(mcp_pkg::REG_MAP_BASE) - mcp_pkg::reg_idx_t'(s);
      end
      return idx;
   endfunction

   assign idx_a = map_sel(rf.sel_a, g);
   assign idx_b = map_sel(rf.sel_b, g);

   assign rf.ra = regs[idx_a];             // combinational reads
   assign rf.rb = regs[idx_b];

   always_ff @(posedge clk)
   begin
      if (rf.we)
         regs[idx_a] <= rf.wdata;          // result goes back through port A
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         g <= '0;
      else if (rf.g_we)
         g <= rf.ra[mcp_pkg::BANK_W-1:0];
   end

endmodule

// File: rtl/mcp_rf_if.sv
// register file access bundle between the control block and the register file
`timescale 1ns/1ps

interface mcp_rf_if;

   mcp_pkg::reg_sel_t sel_a;               // selector of port A, also write target
   mcp_pkg::reg_sel_t sel_b;               // selector of port B
   mcp_pkg::byte_t    ra;                  // port A read data
   mcp_pkg::byte_t    rb;                  // port B read data
   logic              we;                  // write wdata to port A register
   mcp_pkg::byte_t    wdata;
   logic              g_we;                // load G from ra

   modport ctrl
   (
      output sel_a, sel_b, we, wdata, g_we,
      input  ra, rb
   );

   modport rf
   (
      input  sel_a, sel_b, we, wdata, g_we,
      output ra, rb
   );

endinterface

// File: run.sh
#!/usr/bin/env bash
# builds and runs the data chip testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mcp_data_chip.f --top-module tb_mcp_data_chip \
   -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: test/tb_ref.svh
// data chip reference model for the register map, the ALU rules and the LFSR
`ifndef TB_REF_SVH
`define TB_REF_SVH

// selectors 0 and 1 follow G, the others count down from 27
function automatic int ref_index(input logic [3:0] s, input logic [2:0] g);
   int idx;
   if (int'(s) < mcp_pkg::BANKED_SELS)
      idx = 2 * int'(g) + int'(s);
   else
      idx = mcp_pkg::REG_MAP_BASE - int'(s);
   return idx;
endfunction

function automatic logic is_result(input mcp_pkg::alu_fn_t f);
   return f inside {mcp_pkg::FN_ADD, mcp_pkg::FN_ADC, mcp_pkg::FN_SUB, mcp_pkg::FN_AND,
                    mcp_pkg::FN_OR, mcp_pkg::FN_XOR, mcp_pkg::FN_MOVB, mcp_pkg::FN_SHR};
endfunction

// returns {psw after the operation, result}
function automatic logic [15:0] ref_alu(input mcp_pkg::alu_fn_t f, input logic [7:0] a,
                                        input logic [7:0] b, input logic [7:0] p);
   logic [8:0] w;
   logic [7:0] r;
   logic [7:0] np;
   logic       sub;
   np  = p;
   sub = (f == mcp_pkg::FN_SUB);
   w   = {1'b0, a} + {1'b0, b} + {8'h00, (f == mcp_pkg::FN_ADC) & p[mcp_pkg::PSW_C]};
   if (sub)
      w = {1'b0, a} - {1'b0, b};           // bit 8 set on a borrow
   case (f)
      mcp_pkg::FN_AND:  r = a & b;
      mcp_pkg::FN_OR:   r = a | b;
      mcp_pkg::FN_XOR:  r = a ^ b;
      mcp_pkg::FN_MOVB: r = b;
      mcp_pkg::FN_SHR:  r = {p[mcp_pkg::PSW_C], a[7:1]};
      default:          r = w[7:0];
   endcase
   if (is_result(f))
   begin
      np[mcp_pkg::PSW_V] = 1'b0;
      np[mcp_pkg::PSW_Z] = (r == 8'h00);
      np[mcp_pkg::PSW_N] = r[7];
   end
   if (f inside {mcp_pkg::FN_ADD, mcp_pkg::FN_ADC, mcp_pkg::FN_SUB})
   begin
      np[mcp_pkg::PSW_C] = w[8];
      np[mcp_pkg::PSW_V] = (a[7] ^ r[7]) & (sub ? (a[7] ^ b[7]) : ~(a[7] ^ b[7]));
   end
   if (f == mcp_pkg::FN_SHR)
      np[mcp_pkg::PSW_C] = a[0];           // bit shifted out
   if (f == mcp_pkg::FN_LDPSW)
      np = b;
   return {np, r};
endfunction

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: test/tb_mcp_data_chip.sv
// data chip testbench with shadow state model and per-cycle output compare
`timescale 1ns/1ps

module tb_mcp_data_chip;

   localparam int MAX_CYCLES = 6000;

   logic             clk;
   logic             reset;
   mcp_pkg::word_t   mi;
   mcp_pkg::alu_fn_t fn;
   logic             valid;
   logic             wi;
   mcp_pkg::word_t   ad;
   logic             ad_stb;
   mcp_pkg::byte_t   psw;

   mcp_pkg::byte_t   m_regs [mcp_pkg::NUM_REGS];   // shadow registers
   logic [2:0]       m_g;
   mcp_pkg::byte_t   m_psw;
   logic [15:0]      m_ad;
   logic             m_stb;
   mcp_pkg::byte_t   exp_psw;                      // values seen after the last edge
   logic [15:0]      exp_ad;
   logic             exp_stb;
   logic [31:0]      lfsr;
   int               cycles = 0;

   `include "tb_ref.svh"

   mcp_data_chip dut0
   (
      .clk(clk), .reset(reset), .mi(mi), .fn(fn), .valid(valid), .wi(wi),
      .ad(ad), .ad_stb(ad_stb), .psw(psw)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "simulation stopped");
      end
   end

   task automatic check_value(input logic [15:0] got, input logic [15:0] want,
                              input string what);
      if (got !== want)
      begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
         $display("TEST FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic take_bits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         val  = {val[14:0], lfsr[0]};          // one step per bit
      end
   endtask

   function automatic logic [15:0] imm_mi(input logic [3:0] sa, input logic [7:0] imm);
      return {4'h0, imm, sa};
   endfunction

   function automatic logic [15:0] reg_mi(input logic [3:0] sa, input logic [3:0] sb);
      return {8'h80, sb, sa};
   endfunction

   task automatic next_cycle;
      @(posedge clk);
      #1;
      exp_psw = m_psw;
      exp_ad  = m_ad;
      exp_stb = m_stb;
   endtask

   // drive one operation and apply it to the shadow state unless held by wi
   task automatic run_op(input mcp_pkg::alu_fn_t f, input logic [15:0] m, input logic hold);
      int             ia;
      mcp_pkg::byte_t va;
      mcp_pkg::byte_t vb;
      logic [15:0]    r;
      fn    = f;
      mi    = m;
      valid = 1'b1;
      wi    = hold;
      ia    = ref_index(m[3:0], m_g);
      va    = m_regs[ia];
      vb    = m[15] ? m_regs[ref_index(m[7:4], m_g)] : m[11:4];
      r     = ref_alu(f, va, vb, m_psw);
      m_stb = 1'b0;
      if (!hold)
      begin
         m_psw = r[15:8];
         if (is_result(f))
            m_regs[ia] = r[7:0];
         if (f == mcp_pkg::FN_LDG)
            m_g = va[2:0];
         if (f == mcp_pkg::FN_OUT)
         begin
            m_ad  = {vb, va};
            m_stb = 1'b1;
         end
      end
      next_cycle();
   endtask

   // ad, ad_stb and psw checked mid-cycle, from the first cycle out of reset
   initial
   begin
      wait (reset === 1'b0);
      forever
      begin
         @(negedge clk);
         check_value(16'(ad_stb), 16'(exp_stb), "ad_stb");
         check_value(16'(psw), 16'(exp_psw), "psw");
         check_value(ad, exp_ad, "ad");
      end
   end

   initial
   begin
      logic [15:0]      rv;
      logic [15:0]      rm;
      mcp_pkg::alu_fn_t rnd_fn;
      reset     = 1'b1;
      valid     = 1'b0;
      wi        = 1'b0;
      mi        = '0;
      fn        = mcp_pkg::FN_NOP;
      lfsr      = 32'd72389;
      m_g       = 3'd0;
      m_psw     = 8'h00;
      m_ad      = 16'h0000;
      m_stb     = 1'b0;
      exp_psw   = 8'h00;
      exp_ad    = 16'h0000;
      exp_stb   = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      for (int g = 0; g < 8; g++)
      begin
         run_op(mcp_pkg::FN_MOVB, imm_mi(4'd15, 8'(g)), 1'b0);   // bank value via sel 15
         run_op(mcp_pkg::FN_LDG, imm_mi(4'd15, 8'h00), 1'b0);
         for (int s = 0; s < 16; s++)
            run_op(mcp_pkg::FN_MOVB, imm_mi(4'(s), 8'(g * 16 + s) ^ 8'hA5), 1'b0);
         for (int s = 0; s < 16; s++)
            run_op(mcp_pkg::FN_OUT, reg_mi(4'(s), 4'(15 - s)), 1'b0);
      end

      // carry and overflow chains on the stored C
      run_op(mcp_pkg::FN_LDPSW, imm_mi(4'd2, 8'h00), 1'b0);
      run_op(mcp_pkg::FN_MOVB, imm_mi(4'd2, 8'hFF), 1'b0);
      run_op(mcp_pkg::FN_ADD, imm_mi(4'd2, 8'h01), 1'b0);      // carry out, zero
      run_op(mcp_pkg::FN_MOVB, imm_mi(4'd3, 8'h7F), 1'b0);
      run_op(mcp_pkg::FN_ADC, imm_mi(4'd3, 8'h00), 1'b0);      // overflow from carry in
      run_op(mcp_pkg::FN_SUB, imm_mi(4'd2, 8'h80), 1'b0);      // borrow and overflow
      run_op(mcp_pkg::FN_AND, imm_mi(4'd3, 8'hF0), 1'b0);
      run_op(mcp_pkg::FN_OR, reg_mi(4'd3, 4'd2), 1'b0);
      run_op(mcp_pkg::FN_XOR, imm_mi(4'd3, 8'h3C), 1'b0);
      run_op(mcp_pkg::FN_SHR, imm_mi(4'd2, 8'h00), 1'b0);
      run_op(mcp_pkg::FN_MOVB, imm_mi(4'd4, 8'hF0), 1'b0);
      run_op(mcp_pkg::FN_ADD, imm_mi(4'd4, 8'h20), 1'b0);
      run_op(mcp_pkg::FN_ADC, imm_mi(4'd5, 8'h00), 1'b0);      // second byte of the sum
      run_op(mcp_pkg::FN_OUT, reg_mi(4'd4, 4'd5), 1'b0);

      // direct status load and its carry
      run_op(mcp_pkg::FN_LDPSW, imm_mi(4'd0, 8'hF1), 1'b0);
      run_op(mcp_pkg::FN_ADC, imm_mi(4'd6, 8'h00), 1'b0);
      run_op(mcp_pkg::FN_LDPSW, reg_mi(4'd0, 4'd6), 1'b0);
      run_op(mcp_pkg::FN_ADC, imm_mi(4'd7, 8'h10), 1'b0);
      run_op(mcp_pkg::FN_OUT, reg_mi(4'd6, 4'd7), 1'b0);

      for (int k = 0; k < 300; k++)
      begin
         take_bits(4, rv);
         rnd_fn = mcp_pkg::alu_fn_t'(rv[3:0] % 4'd12);
         take_bits(16, rm);
         take_bits(2, rv);
         if (rv[1:0] == 2'b00)
            run_op(rnd_fn, rm, 1'b1);          // held by wi first
         run_op(rnd_fn, rm, 1'b0);
      end

      valid = 1'b0;
      wi    = 1'b0;
      m_stb = 1'b0;
      next_cycle();
      @(negedge clk);
      #1;
      $display("TEST OK");
      $finish;
   end

endmodule
